//--- source/shift_pkg.sv
package shift_pkg;

	// ARM shift_type bits [6:5]
	typedef enum logic [1:0]
	{
		LSL = 2'd0,
		LSR = 2'd1,
		ASR = 2'd2,
		ROR = 2'd3
	} shift_func_e;

	typedef logic [3:0] reg_addr_t;           // One of r0..r15

	// Shift by a 5 bit constant
	typedef struct packed
	{
		logic [4:0]  shift_imm;               // Zero selects the special forms
		shift_func_e shift_type;
		logic        reg_flag;                // Low here
		reg_addr_t   rm;
	} shift_imm_form_t;

	// Shift by the low byte of Rs
	typedef struct packed
	{
		reg_addr_t   rs;
		logic        pad;                     // Must be zero in this form
		shift_func_e shift_type;
		logic        reg_flag;                // High here
		reg_addr_t   rm;
	} shift_reg_form_t;

	// One operand-2 word, read through the view reg_flag selects
	typedef union packed
	{
		shift_imm_form_t imm;
		shift_reg_form_t regs;
	} shift_operand2_u;

endpackage

//--- source/shift_cmd_if.sv
`timescale 1ns/10ps

// Decoded shift command, decoder to barrel shifter
interface shift_cmd_if;
	import shift_pkg::*;

	logic [31:0] data;                        // Rm value
	logic        carry_in;                    // C flag from the request
	logic [7:0]  amount;                      // Rs[7:0] or zero extended immediate
	logic        imm_zero;                    // Immediate form with shift_imm of zero
	shift_func_e func;

	modport src
	(
		output data, carry_in, amount, imm_zero, func
	);

	modport dst
	(
		input data, carry_in, amount, imm_zero, func
	);

endinterface

//--- source/shift_reg_bank.sv
`timescale 1ns/10ps

module shift_reg_bank
(
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	input  logic                 i_wr_en,
	input  shift_pkg::reg_addr_t i_wr_addr,
	input  logic [31:0]          i_wr_data,
	input  shift_pkg::reg_addr_t i_rm_addr,
	input  shift_pkg::reg_addr_t i_rs_addr,
	output logic [31:0]          o_rm_data,
	output logic [31:0]          o_rs_data
);

	logic [31:0] reg_q [0:15];                // r0..r15

	// Single write port
	// Registers come up as zero
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < 16; i++)
			begin
				reg_q[i] <= '0;
			end
		end
		else if (i_wr_en)
		begin
			reg_q[i_wr_addr] <= i_wr_data;    // Visible to reads next cycle
		end
	end

	// Two combinational read ports
	always_comb
	begin
		o_rm_data = reg_q[i_rm_addr];         // Value to be shifted
		o_rs_data = reg_q[i_rs_addr];         // Shift amount source
	end

endmodule

//--- source/shift_operand_decoder.sv
`timescale 1ns/10ps

module shift_operand_decoder
(
	input  shift_pkg::shift_operand2_u i_operand2,
	input  logic [31:0]                i_rm_data,
	input  logic [31:0]                i_rs_data,
	input  logic                       i_carry,
	output shift_pkg::reg_addr_t       o_rm_addr,
	output shift_pkg::reg_addr_t       o_rs_addr,
	shift_cmd_if.src                   cmd
);

	// Rs port address
	// Only the register form uses the data behind it
	assign o_rs_addr = i_operand2.regs.rs;

	always_comb
	begin
		cmd.data     = i_rm_data;             // Rm always shifted
		cmd.carry_in = i_carry;
		o_rm_addr    = i_operand2.imm.rm;     // Same field position in both views
		cmd.func     = i_operand2.imm.shift_type;

		if (i_operand2.imm.reg_flag)
		begin
			// Register specified amount
			cmd.amount   = i_rs_data[7:0];    // Only the low byte of Rs counts
			cmd.imm_zero = 1'b0;              // Rs of zero is a true zero shift
		end
		else
		begin
			// Immediate amount of 0..31
			cmd.amount   = {3'b000, i_operand2.imm.shift_imm};
			// Zero here selects LSR #32, ASR #32 or RRX
			cmd.imm_zero = (i_operand2.imm.shift_imm == 5'd0);
		end
	end

endmodule

//--- source/barrel_shifter.sv
`timescale 1ns/10ps

module barrel_shifter
(
	shift_cmd_if.dst    cmd,
	output logic [31:0] o_result,
	output logic        o_carry
);
	import shift_pkg::*;

	logic [4:0]       shift_amount;           // Amount seen by the rotator
	logic             shift_nzero;            // Nonzero amount
	logic             shift_over;             // 32 or more
	logic             shift_32;               // Exactly 32
	logic             rrx;                    // ROR #0 in the immediate form
	logic             direction;              // Set for right rotation
	logic             asr_sign;               // Fill bit for ASR
	logic [15:0]      low_mask;               // Mask helper from amount[3:0]
	logic [31:0]      base_mask;              // Ones from bit n upwards
	logic [31:0]      lsl_mask;
	logic [31:0]      lsr_mask;
	logic [5:0][31:0] rot_stage;              // Rotator levels with the input at 0
	logic [31:0]      rot_prod;
	logic [31:0]      masked;

	// Amount qualification and the immediate zero forms
	always_comb
	begin
		shift_amount = cmd.amount[4:0];
		shift_over   = |cmd.amount[7:5];
		shift_32     = (cmd.amount == 8'd32);
		shift_nzero  = |cmd.amount;
		rrx          = 1'b0;
		if (cmd.imm_zero)
		begin
			case (cmd.func)
				LSR, ASR:
				begin
					// #0 encodes #32
					shift_nzero = 1'b1;
					shift_over  = 1'b1;
					shift_32    = 1'b1;
				end
				ROR:
				begin
					// RRX is a one bit rotate with C into bit 31
					rrx          = 1'b1;
					shift_amount = 5'd1;
					shift_nzero  = 1'b1;
				end
				default:
				begin
					rrx = 1'b0;               // LSL #0 passes the value through
				end
			endcase
		end
	end

	assign direction = (cmd.func != LSL);     // Only LSL rotates left

	// Five level rotator with one power of two per level
	assign rot_stage[0] = cmd.data;
	for (genvar i = 0; i < 5; i++)
	begin : g_rot
		localparam int step = 1 << i;

		assign rot_stage[i + 1] =
			!shift_amount[i] ? rot_stage[i] :
			direction ? {rot_stage[i][step - 1:0], rot_stage[i][31:step]} :
			{rot_stage[i][31 - step:0], rot_stage[i][31:32 - step]};
	end
	assign rot_prod = rot_stage[5];

	// Masks are ready well before the rotated product
	always_comb
	begin
		low_mask = 16'hffff << shift_amount[3:0];
		if (shift_over)
			base_mask = '0;                   // Everything shifted out
		else if (shift_amount[4])
			base_mask = {low_mask, 16'h0000};
		else
			base_mask = {16'hffff, low_mask};

		// Left mask bites for LSL only
		lsl_mask = (cmd.func == LSL) ? base_mask : '1;
		// Right mask is the left one mirrored
		if (cmd.func == LSR || cmd.func == ASR)
			lsr_mask = bit_swap(base_mask);
		else
			lsr_mask = '1;                    // ROR and LSL keep all bits

		asr_sign = (cmd.func == ASR) && cmd.data[31];
		masked   = (rot_prod & lsl_mask & lsr_mask) | ({32{asr_sign}} & ~lsr_mask);
	end

	// Top bit and carry per function
	always_comb
	begin
		o_result = masked;
		case (cmd.func)
			LSL:
			begin
				if (!shift_nzero)
					o_carry = cmd.carry_in;
				else if (shift_over && !shift_32)
					o_carry = 1'b0;           // Past bit 0 entirely
				else
					o_carry = rot_prod[0];    // Bit 32-n or bit 0 for #32
			end
			LSR:
			begin
				if (!shift_nzero)
					o_carry = cmd.carry_in;
				else if (shift_over && !shift_32)
					o_carry = 1'b0;
				else
					o_carry = rot_prod[31];   // Bit n-1 or bit 31 for #32
			end
			ASR:
			begin
				if (!shift_nzero)
					o_carry = cmd.carry_in;
				else if (shift_over)
					o_carry = cmd.data[31];   // Sign fills everything
				else
					o_carry = rot_prod[31];
			end
			default:
			begin
				// ROR and RRX
				if (rrx)
				begin
					o_result = {cmd.carry_in, masked[30:0]};
					o_carry  = cmd.data[0];
				end
				else if (shift_nzero)
					o_carry = rot_prod[31];   // Also for multiples of 32
				else
					o_carry = cmd.carry_in;
			end
		endcase
	end

	// Mirror a 32 bit word
	function automatic logic [31:0] bit_swap(input logic [31:0] value);
		logic [31:0] swapped;

		for (int i = 0; i < 32; i++)
		begin
			swapped[i] = value[31 - i];
		end
		return swapped;
	endfunction

endmodule

//--- source/shift_handshake_ctrl.sv
`timescale 1ns/10ps

module shift_handshake_ctrl
(
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_req,
	input  shift_pkg::shift_operand2_u i_operand2,
	input  logic                       i_carry,
	output shift_pkg::shift_operand2_u o_operand2,
	output logic                       o_carry_in,
	input  logic [31:0]                i_shift_result,
	input  logic                       i_shift_carry,
	output logic                       o_ack,
	output logic [31:0]                o_result,
	output logic                       o_carry
);

	typedef enum logic
	{
		ST_IDLE,
		ST_BUSY                               // Computing or acknowledged
	} state_e;

	state_e state_q;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state_q  <= ST_IDLE;
			o_ack    <= 1'b0;
			o_result <= '0;
			o_carry  <= 1'b0;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
				begin
					if (i_req)
						state_q <= ST_BUSY;   // Operand captured below
				end
				default:
				begin
					if (!o_ack)
					begin
						// Shifter has settled on the captured operand
						o_result <= i_shift_result;
						o_carry  <= i_shift_carry;
						o_ack    <= 1'b1;
					end
					else if (!i_req)
					begin
						o_ack   <= 1'b0;      // Requester let go
						state_q <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// Operand and flag held for the whole transaction
	always_ff @(posedge i_clk)
	begin
		if (state_q == ST_IDLE && i_req)
		begin
			o_operand2 <= i_operand2;
			o_carry_in <= i_carry;
		end
	end

endmodule

//--- source/shift_unit.sv
`timescale 1ns/10ps

module shift_unit
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_wr_en,                // Register write port
	input  logic [3:0]  i_wr_addr,
	input  logic [31:0] i_wr_data,
	input  logic        i_req,                  // Four phase request
	input  logic [11:0] i_operand2,
	input  logic        i_carry,
	output logic        o_ack,
	output logic [31:0] o_result,
	output logic        o_carry
);
	import shift_pkg::*;

	shift_operand2_u operand2_q;                // Captured operand-2 field
	logic            carry_q;
	reg_addr_t       rm_addr;
	reg_addr_t       rs_addr;
	logic [31:0]     rm_data;
	logic [31:0]     rs_data;
	logic [31:0]     shift_result;
	logic            shift_carry;

	shift_cmd_if cmd_if_i ();

	shift_handshake_ctrl ctrl_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_req(i_req),
		.i_operand2(i_operand2), .i_carry(i_carry),
		.o_operand2(operand2_q), .o_carry_in(carry_q),
		.i_shift_result(shift_result), .i_shift_carry(shift_carry),
		.o_ack(o_ack), .o_result(o_result), .o_carry(o_carry)
	);

	shift_reg_bank bank_i (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_wr_en(i_wr_en),
		.i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
		.i_rm_addr(rm_addr), .i_rs_addr(rs_addr),
		.o_rm_data(rm_data), .o_rs_data(rs_data)
	);

	shift_operand_decoder decoder_i (
		.i_operand2(operand2_q), .i_rm_data(rm_data), .i_rs_data(rs_data),
		.i_carry(carry_q), .o_rm_addr(rm_addr), .o_rs_addr(rs_addr),
		.cmd(cmd_if_i.src)
	);

	barrel_shifter shifter_i (
		.cmd(cmd_if_i.dst), .o_result(shift_result), .o_carry(shift_carry)
	);

endmodule

//--- bench/shift_unit_asserts.sv
`timescale 1ns/10ps

module shift_unit_asserts
(
	input logic        i_clk,
	input logic        i_arst_n,
	input logic        i_wr_en,
	input logic [3:0]  i_wr_addr,
	input logic [31:0] i_wr_data,
	input logic        i_req,
	input logic [11:0] i_operand2,
	input logic        i_carry,
	input logic        o_ack,
	input logic [31:0] o_result,
	input logic        o_carry
);

	logic [31:0] shadow [0:15];               // Mirror of the register bank
	logic [11:0] op_q;                        // Operand seen with the request
	logic        carry_q;
	logic        open_q;                      // Request taken, not yet released
	logic [32:0] exp_q;                       // {C, result} of the open request
	logic [32:0] last_exp;
	logic [32:0] last_act;
	int          value_errs = 0;
	int          protocol_errs = 0;

	// ARM operand-2 shift, {C, result}
	function automatic logic [32:0] arm_shift(input logic [31:0] v, input logic [7:0] n,
		input logic [1:0] func, input logic imm, input logic c);
		logic [31:0] r;
		int          k;

		k = n;
		if (imm && n == 8'd0 && func == 2'd3)
			return {v[0], c, v[31:1]};        // RRX
		if (imm && n == 8'd0 && func != 2'd0)
			k = 32;                           // LSR #32 and ASR #32
		if (k == 0)
			return {c, v};                    // Value and carry pass through
		case (func)
			2'd0: return (k < 32) ? {v[32 - k], v << k} : {k == 32 && v[0], 32'h0};
			2'd1: return (k < 32) ? {v[k - 1], v >> k} : {k == 32 && v[31], 32'h0};
			2'd2:
			begin
				r = $signed(v) >>> k;         // Sign fill, also past 31
				return {(k < 32) ? v[k - 1] : v[31], r};
			end
			default:
			begin
				r = (v >> k[4:0]) | (v << (32 - k[4:0]));
				return {r[31], r};            // Multiples of 32 leave v as is
			end
		endcase
	endfunction

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			open_q  <= 1'b0;
			op_q    <= '0;
			carry_q <= 1'b0;
			exp_q   <= '0;
			for (int i = 0; i < 16; i++)
				shadow[i] <= '0;
		end
		else
		begin
			if (i_wr_en)
				shadow[i_wr_addr] <= i_wr_data;
			if (!open_q && i_req)
			begin
				open_q  <= 1'b1;              // Capture edge
				op_q    <= i_operand2;
				carry_q <= i_carry;
			end
			else if (o_ack && !i_req)
				open_q <= 1'b0;
			// Same edge at which the unit registers its result
			if (open_q && !o_ack)
				exp_q <= arm_shift(shadow[op_q[3:0]],
					op_q[4] ? shadow[op_q[11:8]][7:0] : {3'b000, op_q[11:7]},
					op_q[6:5], !op_q[4], carry_q);
		end
	end

	a_ack_delay: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!open_q && i_req |-> ##2 $rose(o_ack))
		else
		begin
			protocol_errs++;
			$error("o_ack did not rise on the second edge after i_req");
		end

	a_ack_source: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_ack |-> open_q)
		else
		begin
			protocol_errs++;
			$error("o_ack high without a request");
		end

	// Held while i_req stays high, cleared at the edge that sees it low
	a_ack_phase: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_ack |=> o_ack == $past(i_req) && $stable(o_result) && $stable(o_carry))
		else
		begin
			protocol_errs++;
			$error("acknowledge phase broken, o_ack or the result moved");
		end

	a_result: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(o_ack) |-> {o_carry, o_result} == exp_q)
		else
		begin
			value_errs++;
			last_exp = exp_q;
			last_act = {o_carry, o_result};
			$error("shift result or carry differs from the ARM rules");
		end

endmodule

bind shift_unit shift_unit_asserts asserts_i (.*);

//--- bench/tb_shift_unit.sv
`timescale 1ns/10ps

module tb_shift_unit;

	localparam int          PERIOD       = 40;            // ns
	localparam int          RESET_CYCLES = 16;
	localparam int          N_IMM        = 24;            // Random immediate shifts
	localparam int          N_TRANS      = 60;            // Bound on all transactions
	localparam logic [31:0] SEED         = 32'ha6a2e1f6;
	localparam logic [31:0] TAPS         = 32'h80200003;  // x^32+x^22+x^2+x+1

	logic        i_clk;
	logic        i_arst_n;
	logic        i_wr_en;
	logic [3:0]  i_wr_addr;
	logic [31:0] i_wr_data;
	logic        i_req;
	logic [11:0] i_operand2;
	logic        i_carry;
	logic        o_ack;
	logic [31:0] o_result;
	logic        o_carry;
	logic [31:0] lfsr = SEED;
	int          n_trans = 0;
	int          hs_errs = 0;                             // Handshake timeouts

	shift_unit shift_unit_i (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #(PERIOD / 2) i_clk = ~i_clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// Called at a falling edge, returns at the next one
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		i_wr_en   = 1'b1;
		i_wr_addr = addr;
		i_wr_data = data;
		@(negedge i_clk);
		i_wr_en = 1'b0;
	endtask

	// Full four phase transaction, hold extends the acknowledged phase
	task automatic run_shift(input string name, input logic [11:0] op, input logic c,
		input int hold);
		int waited;
		int value_before;
		int proto_before;

		value_before = shift_unit_i.asserts_i.value_errs;
		proto_before = shift_unit_i.asserts_i.protocol_errs;
		i_req        = 1'b1;
		i_operand2   = op;
		i_carry      = c;
		waited       = 0;
		while (!o_ack && waited < 4)
		begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_ack)
		begin
			hs_errs++;
			$display("%s: no acknowledge within 4 cycles of the request", name);
		end
		repeat (hold) @(negedge i_clk);
		i_req  = 1'b0;
		waited = 0;
		while (o_ack && waited < 4)
		begin
			@(negedge i_clk);
			waited++;
		end
		if (o_ack)
		begin
			hs_errs++;
			$display("%s: acknowledge still high 4 cycles after the request dropped", name);
		end
		n_trans++;
		if (shift_unit_i.asserts_i.value_errs != value_before)
			$display("FAILED %s expected %h actual %h", name,
				shift_unit_i.asserts_i.last_exp, shift_unit_i.asserts_i.last_act);
		if (shift_unit_i.asserts_i.protocol_errs != proto_before)
			$display("%s: handshake assertion failed", name);
	endtask

	initial
	begin
		logic [31:0] v;
		logic [31:0] a;
		logic [31:0] f;
		logic [31:0] rm;
		logic [31:0] c;
		int          errors;

		i_arst_n   = 1'b0;
		i_wr_en    = 1'b0;
		i_wr_addr  = '0;
		i_wr_data  = '0;
		i_req      = 1'b0;
		i_operand2 = '0;
		i_carry    = 1'b0;
		repeat (RESET_CYCLES) @(negedge i_clk);
		i_arst_n = 1'b1;
		repeat (3) @(negedge i_clk);                       // Idle, o_ack must stay low

		for (int r = 0; r < 16; r++)
		begin
			take_bits(32, v);
			write_reg(r[3:0], v);
		end

		// Immediate amounts 1..31, some with back-pressure
		for (int i = 0; i < N_IMM; i++)
		begin
			take_bits(2, f);
			take_bits(5, a);
			take_bits(4, rm);
			take_bits(1, c);
			a = {27'd0, (a[4:0] == 5'd0) ? 5'd1 : a[4:0]};
			run_shift("imm_shift", {a[4:0], f[1:0], 1'b0, rm[3:0]}, c[0], i % 3);
		end

		take_bits(31, v);
		write_reg(4'd1, {1'b0, v[30:0]});                 // r1 positive
		take_bits(31, v);
		write_reg(4'd2, {1'b1, v[30:0]});                 // r2 negative
		take_bits(1, c);
		run_shift("lsl_0", 12'h001, c[0], 0);
		run_shift("lsr_32", 12'h022, c[0], 0);
		run_shift("asr_32_pos", 12'h041, c[0], 0);
		run_shift("asr_32_neg", 12'h042, c[0], 0);
		run_shift("rrx_c0", 12'h062, 1'b0, 0);
		run_shift("rrx_c1", 12'h061, 1'b1, 0);

		// Rs in r15, amounts 0, 1..31, 32, 33..255 and free
		for (int t = 0; t < 4; t++)
		begin
			for (int k = 0; k < 5; k++)
			begin
				take_bits(32, v);
				case (k)
					0:       a = '0;
					1:       a = {27'd0, (v[4:0] == 5'd0) ? 5'd1 : v[4:0]};
					2:       a = 32'd32;
					3:       a = {24'd0, (v[7:0] < 8'd33) ? v[7:0] + 8'd33 : v[7:0]};
					default: a = {24'd0, v[7:0]};
				endcase
				take_bits(4, rm);
				take_bits(1, c);
				write_reg(4'd15, {v[31:8], a[7:0]});      // Upper Rs bits are noise
				rm = {28'd0, (rm[3:0] == 4'd15) ? 4'd14 : rm[3:0]};
				run_shift("reg_shift", {4'd15, 1'b0, t[1:0], 1'b1, rm[3:0]}, c[0], 0);
			end
		end

		// Fresh Rm written right before the request, long acknowledged phase
		take_bits(32, v);
		write_reg(4'd3, v);
		run_shift("write_then_read", {5'd7, 2'd3, 1'b0, 4'd3}, 1'b0, 5);

		repeat (2) @(negedge i_clk);
		errors = hs_errs + shift_unit_i.asserts_i.value_errs
			+ shift_unit_i.asserts_i.protocol_errs;
		$display("%0d transactions, %0d value errors, %0d protocol errors, %0d handshake errors",
			n_trans, shift_unit_i.asserts_i.value_errs,
			shift_unit_i.asserts_i.protocol_errs, hs_errs);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Twelve cycles per transaction plus reset, loads and idle time
	initial
	begin
		#((N_TRANS * 12 + RESET_CYCLES + 96) * PERIOD);
		$display("Watchdog timeout, the run did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- project.f
source/shift_pkg.sv
source/shift_cmd_if.sv
source/shift_reg_bank.sv
source/shift_operand_decoder.sv
source/barrel_shifter.sv
source/shift_handshake_ctrl.sv
source/shift_unit.sv
bench/shift_unit_asserts.sv
bench/tb_shift_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the shift unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_shift_unit \
	-f project.f -Mdir obj_dir -o sim_shift_unit > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_shift_unit +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
